// File: core_pkg.sv
/*
  Shared definitions for the three-stage execution pipeline.
  Holds the data and register widths, the data memory size, the opcode
  encoding and the bit positions of the instruction fields. Modules and
  the stage interface import this package with a wildcard import.
*/
package core_pkg;

  // Widths and sizes
  localparam int data_width_lp      = 32;
  localparam int reg_addr_width_lp  = 3;
  localparam int num_regs_lp        = 8;
  localparam int dmem_addr_width_lp = 8;
  localparam int dmem_words_lp      = 256;
  localparam int imm_width_lp       = 16;
  localparam int pc_step_lp         = 4;

  // Instruction field layout
  localparam int op_msb_lp  = 31;
  localparam int op_lsb_lp  = 28;
  localparam int rd_msb_lp  = 27;
  localparam int rd_lsb_lp  = 25;
  localparam int rs1_msb_lp = 24;
  localparam int rs1_lsb_lp = 22;
  localparam int rs2_msb_lp = 21;
  localparam int rs2_lsb_lp = 19;
  localparam int imm_msb_lp = 15;
  localparam int imm_lsb_lp = 0;

  localparam int op_width_lp = op_msb_lp - op_lsb_lp + 1;

  // Codes above OP_SW decode as OP_NOP
  typedef enum logic [op_width_lp-1:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_ADDI = 4'h3,
    OP_LW   = 4'h4,
    OP_SW   = 4'h5
  } opcode_e;

endpackage

// File: exe_stage.sv
/*
  Execute stage with the host intake.
  Accepts instruction words from a write-only Wishbone classic slave,
  tags each with a PC, decodes it, forwards operands from the memory and
  writeback registers and computes the ALU value or data memory index.
  A load feeding the next instruction withholds ack for one cycle.
*/
`timescale 1ns/1ps

module exe_stage
  import core_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [data_width_lp-1:0]     wb_dat_i,
  output logic                         wb_ack_o,
  output logic [reg_addr_width_lp-1:0] rs1_addr_o,
  output logic [reg_addr_width_lp-1:0] rs2_addr_o,
  input  logic [data_width_lp-1:0]     rs1_data_i,
  input  logic [data_width_lp-1:0]     rs2_data_i,
  stage_if.dst                         mem_fwd,
  stage_if.dst                         wb_fwd,
  stage_if.src                         out
);

  logic                          exe_v_r;
  logic [data_width_lp-1:0]      exe_pc_r;
  logic [data_width_lp-1:0]      exe_instr_r;
  logic [data_width_lp-1:0]      pc_cnt_r;
  logic [op_width_lp-1:0]        op_raw;
  opcode_e                       opcode;
  logic [reg_addr_width_lp-1:0]  rd, rs1, rs2;
  logic [data_width_lp-1:0]      imm_ext;
  logic                          uses_rs1, uses_rs2, writes_rd;
  logic [data_width_lp-1:0]      op_a, op_b, addr_sum, alu;
  logic                          stall;

  // Youngest producer wins; a load in the memory register has no data yet
  function automatic logic [data_width_lp-1:0] operand(
    input logic [reg_addr_width_lp-1:0] addr,
    input logic [data_width_lp-1:0]     rf_data
  );
    if (mem_fwd.valid && mem_fwd.wen && !mem_fwd.is_load && mem_fwd.rd == addr)
      return mem_fwd.result;
    if (wb_fwd.valid && wb_fwd.wen && wb_fwd.rd == addr)
      return wb_fwd.result;
    return rf_data;
  endfunction

  assign op_raw  = exe_instr_r[op_msb_lp:op_lsb_lp];
  assign opcode  = (op_raw > op_width_lp'(OP_SW)) ? OP_NOP : opcode_e'(op_raw);
  assign rd      = exe_instr_r[rd_msb_lp:rd_lsb_lp];
  assign rs1     = exe_instr_r[rs1_msb_lp:rs1_lsb_lp];
  assign rs2     = exe_instr_r[rs2_msb_lp:rs2_lsb_lp];
  assign imm_ext = {{(data_width_lp-imm_width_lp){exe_instr_r[imm_msb_lp]}},
                    exe_instr_r[imm_msb_lp:imm_lsb_lp]};

  assign uses_rs1  = opcode inside {OP_ADD, OP_SUB, OP_ADDI, OP_LW, OP_SW};
  assign uses_rs2  = opcode inside {OP_ADD, OP_SUB, OP_SW};
  assign writes_rd = opcode inside {OP_ADD, OP_SUB, OP_ADDI, OP_LW};

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  // Also follows the forwarding registers while the operands stay put
  always_comb begin
    op_a = operand(rs1, rs1_data_i);
    op_b = operand(rs2, rs2_data_i);
  end

  assign addr_sum = op_a + imm_ext;

  always_comb begin
    case (opcode)
      OP_ADD:               alu = op_a + op_b;
      OP_SUB:               alu = op_a - op_b;
      OP_ADDI, OP_LW, OP_SW: alu = addr_sum;
      default:              alu = '0;
    endcase
  end

  // Load in memory register feeds the instruction sitting in execute
  assign stall = exe_v_r && mem_fwd.valid && mem_fwd.is_load && mem_fwd.wen &&
                 ((uses_rs1 && rs1 == mem_fwd.rd) || (uses_rs2 && rs2 == mem_fwd.rd));

  assign wb_ack_o = wb_cyc_i && wb_stb_i && wb_we_i && !stall;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_v_r  <= 1'b0;
      pc_cnt_r <= '0;
    end else if (!stall) begin
      exe_v_r <= wb_ack_o;
      if (wb_ack_o)
        pc_cnt_r <= pc_cnt_r + data_width_lp'(pc_step_lp);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_ack_o) begin
      exe_instr_r <= wb_dat_i;
      exe_pc_r    <= pc_cnt_r;
    end
  end

  // Memory register, a bubble while stalled
  always_ff @(posedge clk_i) begin
    if (reset_i)
      out.valid <= 1'b0;
    else
      out.valid <= exe_v_r && !stall;
  end

  always_ff @(posedge clk_i) begin
    out.pc         <= exe_pc_r;
    out.instr      <= exe_instr_r;
    out.opcode     <= opcode;
    out.rd         <= rd;
    out.wen        <= writes_rd && (rd != '0);
    out.result     <= alu;
    out.is_load    <= (opcode == OP_LW);
    out.is_store   <= (opcode == OP_SW);
    out.dmem_addr  <= addr_sum[dmem_addr_width_lp-1:0];
    out.store_data <= op_b;
  end

endmodule

// File: mem_stage.sv
/*
  Memory stage with the local data memory.
  Stores write the word index given by execute, loads read it into the
  result field. The record, with load data in place, is registered into
  the writeback register one cycle after it enters the memory register.
*/
`timescale 1ns/1ps

module mem_stage
  import core_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  stage_if.dst in,
  stage_if.src out
);

  logic [data_width_lp-1:0] dmem_r [dmem_words_lp];

  always_ff @(posedge clk_i) begin
    if (in.valid && in.is_store)
      dmem_r[in.dmem_addr] <= in.store_data;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      out.valid <= 1'b0;
    else
      out.valid <= in.valid;
  end

  always_ff @(posedge clk_i) begin
    out.pc         <= in.pc;
    out.instr      <= in.instr;
    out.opcode     <= in.opcode;
    out.rd         <= in.rd;
    out.wen        <= in.wen;
    out.is_load    <= in.is_load;
    out.is_store   <= in.is_store;
    out.dmem_addr  <= in.dmem_addr;
    out.store_data <= in.store_data;
    // Load data replaces the address sum
    if (in.opcode == OP_LW)
      out.result <= dmem_r[in.dmem_addr];
    else
      out.result <= in.result;
  end

endmodule

// File: reg_file.sv
/*
  Integer register file with two combinational read ports and one
  write port. Register 0 always reads as zero. Written by the writeback
  stage at the end of the writeback cycle.
*/
`timescale 1ns/1ps

module reg_file
  import core_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [reg_addr_width_lp-1:0] rs1_addr_i,
  input  logic [reg_addr_width_lp-1:0] rs2_addr_i,
  output logic [data_width_lp-1:0]     rs1_data_o,
  output logic [data_width_lp-1:0]     rs2_data_o,
  input  logic                         wen_i,
  input  logic [reg_addr_width_lp-1:0] waddr_i,
  input  logic [data_width_lp-1:0]     wdata_i
);

  logic [data_width_lp-1:0] regs_r [num_regs_lp];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < num_regs_lp; i++)
        regs_r[i] <= '0;
    end else if (wen_i) begin
      regs_r[waddr_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_r[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_r[rs2_addr_i];

endmodule

// File: stage_if.sv
/*
  One instruction's results as they travel between pipeline registers.
  The owning stage drives every field through src, the next stage and
  the forwarding logic read them through dst. valid low marks a bubble.
*/
`timescale 1ns/1ps

interface stage_if
  import core_pkg::*;
();

  logic                          valid;
  logic [data_width_lp-1:0]      pc;
  logic [data_width_lp-1:0]      instr;
  opcode_e                       opcode;
  logic [reg_addr_width_lp-1:0]  rd;
  logic                          wen;
  logic [data_width_lp-1:0]      result;
  logic                          is_load;
  logic                          is_store;
  logic [dmem_addr_width_lp-1:0] dmem_addr;
  logic [data_width_lp-1:0]      store_data;

  modport src (output valid, pc, instr, opcode, rd, wen, result,
               is_load, is_store, dmem_addr, store_data);

  modport dst (input valid, pc, instr, opcode, rd, wen, result,
               is_load, is_store, dmem_addr, store_data);

endinterface

// File: tiny_core.f
core_pkg.sv
stage_if.sv
exe_stage.sv
reg_file.sv
mem_stage.sv
wb_stage.sv
tiny_core.sv
tiny_core_assert.sv
tiny_core_tb.sv

// File: tiny_core.sv
/*
  Top level of the three-stage pipeline.
  A host writes instruction words over the Wishbone port; every retired
  instruction shows up on the trace ports two edges after acceptance,
  or three when it waited behind a load.
*/
`timescale 1ns/1ps

module tiny_core
  import core_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [data_width_lp-1:0]      wb_dat_i,
  output logic                          wb_ack_o,
  output logic                          trace_v_o,
  output logic [data_width_lp-1:0]      trace_pc_o,
  output logic [data_width_lp-1:0]      trace_instr_o,
  output logic                          trace_wen_o,
  output logic [reg_addr_width_lp-1:0]  trace_rd_o,
  output logic [data_width_lp-1:0]      trace_wdata_o,
  output logic                          trace_load_o,
  output logic                          trace_store_o,
  output logic [dmem_addr_width_lp-1:0] trace_addr_o,
  output logic [data_width_lp-1:0]      trace_mem_data_o
);

  logic [reg_addr_width_lp-1:0] rs1_addr, rs2_addr, rf_waddr;
  logic [data_width_lp-1:0]     rs1_data, rs2_data, rf_wdata;
  logic                         rf_wen;

  // Memory register and writeback register
  stage_if exe_to_mem ();
  stage_if mem_to_wb ();

  exe_stage exe_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_o   (wb_ack_o),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .mem_fwd    (exe_to_mem.dst),
    .wb_fwd     (mem_to_wb.dst),
    .out        (exe_to_mem.src)
  );

  reg_file rf_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wen_i      (rf_wen),
    .waddr_i    (rf_waddr),
    .wdata_i    (rf_wdata)
  );

  mem_stage mem_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in      (exe_to_mem.dst),
    .out     (mem_to_wb.src)
  );

  wb_stage wb_i (
    .in               (mem_to_wb.dst),
    .rf_wen_o         (rf_wen),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .trace_v_o        (trace_v_o),
    .trace_pc_o       (trace_pc_o),
    .trace_instr_o    (trace_instr_o),
    .trace_wen_o      (trace_wen_o),
    .trace_rd_o       (trace_rd_o),
    .trace_wdata_o    (trace_wdata_o),
    .trace_load_o     (trace_load_o),
    .trace_store_o    (trace_store_o),
    .trace_addr_o     (trace_addr_o),
    .trace_mem_data_o (trace_mem_data_o)
  );

endmodule

// File: tiny_core_assert.sv
/*
  Concurrent checks on the host port and the trace port of the pipeline.
  Bound into every tiny_core instance, so it needs no wiring in the
  testbench.
*/
`timescale 1ns/1ps

module tiny_core_assert (
  input logic clk_i,
  input logic reset_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic trace_v_i,
  input logic trace_wen_i,
  input logic trace_load_i,
  input logic trace_store_i
);

  ack_needs_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_i |-> (cyc_i && stb_i))
    else $error("ack seen without an active bus cycle and strobe");

  // Register write and load flags only inside a valid record
  flags_need_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    (trace_wen_i || trace_load_i) |-> trace_v_i)
    else $error("trace flag raised outside a valid trace record");

  load_store_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(trace_load_i && trace_store_i))
    else $error("trace record marked as both load and store");

endmodule

bind tiny_core tiny_core_assert assert_i (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .cyc_i         (wb_cyc_i),
  .stb_i         (wb_stb_i),
  .ack_i         (wb_ack_o),
  .trace_v_i     (trace_v_o),
  .trace_wen_i   (trace_wen_o),
  .trace_load_i  (trace_load_o),
  .trace_store_i (trace_store_o)
);

// File: tiny_core_tb.sv
/*
  Directed testbench for the three-stage pipeline.
  Pushes instruction words over the Wishbone port, predicts each trace
  record with a register and memory model, and checks every record,
  its order and the edge it retires on. Run with tiny_core_tb as top.
*/
`timescale 1ns/1ps

module tiny_core_tb
  import core_pkg::*;
();

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        wen;
    logic [2:0]  rd;
    logic [31:0] wdata;
    logic        load;
    logic        store;
    logic [7:0]  addr;
    logic [31:0] mdata;
    logic [31:0] edge_n;
  } trace_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        wb_cyc, wb_stb, wb_we, wb_ack;
  logic [31:0] wb_dat;
  logic        trace_v, trace_wen, trace_load, trace_store;
  logic [31:0] trace_pc, trace_instr, trace_wdata, trace_mem_data;
  logic [2:0]  trace_rd;
  logic [7:0]  trace_addr;

  // Reference model state
  logic [31:0] regs_m [8];
  logic [31:0] dmem_m [256];
  logic [31:0] pc_m;
  logic [2:0]  prev_rd;
  bit          prev_load;
  int          prev_mem_edge;
  trace_t      exp_q [$];
  int          cycle = 0;
  int          pushed = 0;
  int          n_pass = 0;
  int          n_fail = 0;

  tiny_core dut_i (
    .clk_i            (clk),
    .reset_i          (reset),
    .wb_cyc_i         (wb_cyc),
    .wb_stb_i         (wb_stb),
    .wb_we_i          (wb_we),
    .wb_dat_i         (wb_dat),
    .wb_ack_o         (wb_ack),
    .trace_v_o        (trace_v),
    .trace_pc_o       (trace_pc),
    .trace_instr_o    (trace_instr),
    .trace_wen_o      (trace_wen),
    .trace_rd_o       (trace_rd),
    .trace_wdata_o    (trace_wdata),
    .trace_load_o     (trace_load),
    .trace_store_o    (trace_store),
    .trace_addr_o     (trace_addr),
    .trace_mem_data_o (trace_mem_data)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] enc(input logic [3:0] op, input int rd, input int rs1,
                                      input int rs2, input int imm);
    logic [31:0] w;
    w = '0;
    w[op_msb_lp:op_lsb_lp]   = op;
    w[rd_msb_lp:rd_lsb_lp]   = rd[2:0];
    w[rs1_msb_lp:rs1_lsb_lp] = rs1[2:0];
    w[rs2_msb_lp:rs2_lsb_lp] = rs2[2:0];
    w[imm_msb_lp:imm_lsb_lp] = imm[15:0];
    return w;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      n_pass++;
    else begin
      n_fail++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  // Strobes stay up on return so the next push can follow back to back
  task automatic push_instr(input logic [31:0] word, output int waits);
    trace_t      r;
    logic [3:0]  op;
    logic [2:0]  rd, rs1, rs2;
    logic [31:0] a, b, imm;
    bit          reads;
    int          acc, stall;
    waits = 0;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b1;
    wb_dat = word;
    #1;
    while (!wb_ack) begin
      waits++;
      @(negedge clk);
      #1;
    end
    acc = cycle + 1;
    pushed++;
    op = word[op_msb_lp:op_lsb_lp];
    if (op > 4'(OP_SW))
      op = 4'(OP_NOP);
    rd  = word[rd_msb_lp:rd_lsb_lp];
    rs1 = word[rs1_msb_lp:rs1_lsb_lp];
    rs2 = word[rs2_msb_lp:rs2_lsb_lp];
    a   = regs_m[rs1];
    b   = regs_m[rs2];
    imm = {{16{word[imm_msb_lp]}}, word[imm_msb_lp:imm_lsb_lp]};
    r = '0;
    r.pc    = pc_m;
    r.instr = word;
    r.rd    = rd;
    r.addr  = 8'(a + imm);
    case (op)
      OP_ADD:  r.wdata = a + b;
      OP_SUB:  r.wdata = a - b;
      OP_ADDI: r.wdata = a + imm;
      OP_LW:   r.wdata = dmem_m[r.addr];
      default: r.wdata = '0;
    endcase
    r.wen   = (op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LW}) && (rd != 3'd0);
    r.load  = (op == OP_LW);
    r.store = (op == OP_SW);
    r.mdata = r.store ? b : r.wdata;
    if (r.store)
      dmem_m[r.addr] = b;
    if (r.wen)
      regs_m[rd] = r.wdata;
    // One bubble when the load just ahead is still in the memory register
    reads = ((op inside {OP_ADD, OP_SUB, OP_SW}) && rs2 == prev_rd) ||
            ((op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LW, OP_SW}) && rs1 == prev_rd);
    stall = (prev_load && prev_mem_edge == acc && reads) ? 1 : 0;
    r.edge_n = acc + 2 + stall;
    prev_load     = r.load && (rd != 3'd0);
    prev_rd       = rd;
    prev_mem_edge = acc + 1 + stall;
    pc_m = pc_m + 4;
    exp_q.push_back(r);
  endtask

  task automatic drain();
    idle(1);
    while (exp_q.size() != 0)
      idle(1);
    idle(3);
  endtask

  task automatic report_test(input string name, input int f0);
    drain();
    $display("%s: finished with %0d errors", name, n_fail - f0);
  endtask

  always @(negedge clk) begin
    trace_t e;
    if (!reset && trace_v) begin
      assert (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        check_value("trace pc", trace_pc, e.pc);
        check_value("trace instr", trace_instr, e.instr);
        check_value("trace wen", trace_wen, e.wen);
        if (e.wen) begin
          check_value("trace rd", trace_rd, e.rd);
          check_value("trace wdata", trace_wdata, e.wdata);
        end
        check_value("trace load", trace_load, e.load);
        check_value("trace store", trace_store, e.store);
        if (e.load || e.store) begin
          check_value("trace addr", trace_addr, e.addr);
          check_value("trace mem data", trace_mem_data, e.mdata);
        end
        check_value("retire edge", cycle, e.edge_n);
      end else begin
        n_fail++;
        $display("Trace record at %0t with no instruction outstanding", $time);
      end
    end
  end

  task automatic reset_and_pc();
    int f0, w;
    f0 = n_fail;
    check_value("ack after reset", wb_ack, 0);
    check_value("trace valid after reset", trace_v, 0);
    push_instr(enc(OP_NOP, 0, 0, 0, 0), w);
    push_instr(enc(OP_ADDI, 2, 0, 0, 1), w);
    idle(2);
    push_instr(enc(OP_NOP, 5, 3, 6, 16'h7777), w);
    push_instr(enc(4'hc, 1, 1, 1, 12), w);
    report_test("reset and pc", f0);
  endtask

  task automatic forwarding_chains();
    int f0, w;
    f0 = n_fail;
    push_instr(enc(OP_ADDI, 1, 0, 0, 5), w);
    push_instr(enc(OP_ADD, 2, 1, 1, 0), w);
    push_instr(enc(OP_SUB, 3, 2, 1, 0), w);
    push_instr(enc(OP_ADDI, 4, 3, 0, -3), w);
    push_instr(enc(OP_ADD, 5, 4, 2, 0), w);
    push_instr(enc(OP_SUB, 6, 1, 5, 0), w);
    // r0 discards the write
    push_instr(enc(OP_ADDI, 0, 6, 0, 99), w);
    push_instr(enc(OP_ADD, 7, 0, 1, 0), w);
    report_test("forwarding", f0);
  endtask

  task automatic store_load_wrap();
    int f0, w;
    f0 = n_fail;
    push_instr(enc(OP_ADDI, 1, 0, 0, 16'h1234), w);
    push_instr(enc(OP_SW, 0, 0, 1, 10), w);
    push_instr(enc(OP_LW, 2, 0, 0, 10), w);
    push_instr(enc(OP_ADDI, 3, 0, 0, 250), w);
    push_instr(enc(OP_ADDI, 1, 1, 0, 7), w);
    // 250 + 9 wraps to word 3
    push_instr(enc(OP_SW, 0, 3, 1, 9), w);
    push_instr(enc(OP_LW, 4, 3, 0, 9), w);
    push_instr(enc(OP_LW, 5, 3, 0, -247), w);
    report_test("store and load", f0);
  endtask

  task automatic load_use_stall();
    int f0, w;
    f0 = n_fail;
    push_instr(enc(OP_ADDI, 1, 0, 0, 21), w);
    push_instr(enc(OP_SW, 0, 0, 1, 40), w);
    push_instr(enc(OP_LW, 3, 0, 0, 40), w);
    push_instr(enc(OP_ADD, 4, 3, 1, 0), w);
    push_instr(enc(OP_ADDI, 5, 4, 0, 1), w);
    check_value("ack wait cycles after load use", w, 1);
    push_instr(enc(OP_LW, 3, 0, 0, 40), w);
    push_instr(enc(OP_ADDI, 6, 0, 0, 2), w);
    push_instr(enc(OP_ADD, 4, 3, 1, 0), w);
    push_instr(enc(OP_ADDI, 5, 4, 0, 1), w);
    check_value("ack wait cycles without stall", w, 0);
    report_test("load use stall", f0);
  endtask

  task automatic random_mix();
    int         f0, w, kind;
    logic [3:0] op;
    f0 = n_fail;
    // Words 0 to 15 get known contents for the loads
    for (int i = 0; i < 16; i++) begin
      push_instr(enc(OP_ADDI, 1, 0, 0, 16'h0a31 * (i + 1)), w);
      push_instr(enc(OP_SW, 0, 0, 1, i), w);
    end
    for (int i = 0; i < 200; i++) begin
      kind = $urandom_range(6);
      op = (kind == 6) ? 4'($urandom_range(15, 6)) : 4'(kind);
      if (op == OP_LW)
        push_instr(enc(op, $urandom_range(7), 0, 0, $urandom_range(15)), w);
      else
        push_instr(enc(op, $urandom_range(7), $urandom_range(7), $urandom_range(7),
                       $urandom), w);
      if ($urandom_range(3) == 0)
        idle($urandom_range(3));
    end
    report_test("random mix", f0);
  endtask

  // Bound grows with every accepted word and stops when the bus hangs
  initial begin
    while (cycle < 200 + 50 * pushed)
      @(negedge clk);
    $display("Timeout: the run did not finish within %0d cycles", cycle);
    $display("Something failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hec54));
    reset  = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_dat = '0;
    for (int i = 0; i < 8; i++)
      regs_m[i] = '0;
    pc_m          = '0;
    prev_load     = 1'b0;
    prev_rd       = '0;
    prev_mem_edge = 0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    reset_and_pc();
    forwarding_chains();
    store_load_wrap();
    load_use_stall();
    random_mix();
    $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: wb_stage.sv
/*
  Writeback stage.
  Turns the writeback register into the register file write and into
  the trace record on the top-level ports. The record is present for
  the single cycle the instruction sits in writeback.
*/
`timescale 1ns/1ps

module wb_stage
  import core_pkg::*;
(
  stage_if.dst                          in,
  output logic                          rf_wen_o,
  output logic [reg_addr_width_lp-1:0]  rf_waddr_o,
  output logic [data_width_lp-1:0]      rf_wdata_o,
  output logic                          trace_v_o,
  output logic [data_width_lp-1:0]      trace_pc_o,
  output logic [data_width_lp-1:0]      trace_instr_o,
  output logic                          trace_wen_o,
  output logic [reg_addr_width_lp-1:0]  trace_rd_o,
  output logic [data_width_lp-1:0]      trace_wdata_o,
  output logic                          trace_load_o,
  output logic                          trace_store_o,
  output logic [dmem_addr_width_lp-1:0] trace_addr_o,
  output logic [data_width_lp-1:0]      trace_mem_data_o
);

  // Register 0 never gets written
  assign rf_wen_o   = in.valid && in.wen && (in.rd != '0);
  assign rf_waddr_o = in.rd;
  assign rf_wdata_o = in.result;

  assign trace_v_o     = in.valid;
  assign trace_pc_o    = in.pc;
  assign trace_instr_o = in.instr;
  assign trace_wen_o   = rf_wen_o;
  assign trace_rd_o    = in.rd;
  assign trace_wdata_o = in.result;
  assign trace_load_o  = in.valid && in.is_load;
  assign trace_store_o = in.valid && in.is_store;
  assign trace_addr_o  = in.dmem_addr;

  // Stored value for a store, loaded value otherwise
  assign trace_mem_data_o = in.is_store ? in.store_data : in.result;

endmodule
